//--- tb/datapath_stimulus.txt
// test strobes reg_ext(load<<16|drive) op mem_data in_port check expected
// check: 0 none, 1 bus, 2 mar_address, 3 mdr_write_data, 4 out_port, 5 con_flag
0 00000010 00000000 00 00000000 00000000 1 00000100
0 00000008 00000000 00 00000000 00000000 1 00000000
0 00000001 00000000 00 00000000 00000000 1 00000000
0 00000000 00000020 00 00000000 00000000 1 00000000
1 02008000 00000000 00 CAFE1234 00000000 0 00000000
1 00000020 00080000 00 00000000 00000000 1 CAFE1234
1 00004000 00000008 00 00000000 00000000 1 CAFE1234
1 00000000 00000000 00 00000000 00000000 2 CAFE1234
2 02008000 00000000 00 F000000F 00000000 0 00000000
2 00000420 00000000 00 00000000 00000000 1 F000000F
2 02008000 00000000 00 00000004 00000000 0 00000000
2 00000020 00040000 00 00000000 00000000 1 00000004
2 00000800 00000004 03 00000000 00000000 0 00000000
2 00000008 00000000 00 00000000 00000000 1 F0000013
2 00000800 00000004 04 00000000 00000000 0 00000000
2 00000008 00000000 00 00000000 00000000 1 F000000B
2 00000800 00000004 05 00000000 00000000 0 00000000
2 00000008 00000000 00 00000000 00000000 1 00000004
2 00000800 00000004 06 00000000 00000000 0 00000000
2 00000008 00000000 00 00000000 00000000 1 F000000F
2 00000800 00000004 09 00000000 00000000 0 00000000
2 00000008 00000000 00 00000000 00000000 1 0F000000
2 00000800 00000004 0A 00000000 00000000 0 00000000
2 00000008 00000000 00 00000000 00000000 1 FF000000
2 00000800 00000004 0B 00000000 00000000 0 00000000
2 00000008 00000000 00 00000000 00000000 1 000000F0
2 00000800 00000004 07 00000000 00000000 0 00000000
2 00000008 00000000 00 00000000 00000000 1 FF000000
2 00000800 00000004 08 00000000 00000000 0 00000000
2 00000008 00000000 00 00000000 00000000 1 000000FF
2 00000800 00000004 10 00000000 00000000 0 00000000
2 00000008 00000000 00 00000000 00000000 1 C000003C
2 00000004 00000000 00 00000000 00000000 1 FFFFFFFF
2 00000800 00000004 11 00000000 00000000 0 00000000
2 00000008 00000000 00 00000000 00000000 1 FFFFFFFC
2 00000800 00000004 12 00000000 00000000 0 00000000
2 00000008 00000000 00 00000000 00000000 1 FFFFFFFB
3 02008000 00000000 00 029C8001 00000000 0 00000000
3 00000220 00000000 00 00000000 00000000 1 029C8001
3 00480000 00000000 00 00000000 00000000 1 CAFE1234
3 00240080 00000000 00 00000000 00000000 1 FFFC8001
3 00440000 00000000 00 00000000 00000000 1 FFFC8001
3 00300000 00000008 00 00000000 00000000 1 CAFE1234
3 00000000 00000200 00 00000000 00000000 1 CAFE1234
3 00000000 00010008 00 00000000 00000000 1 CAFE1234
3 00800000 00000001 00 00000000 00000000 1 00000000
4 01000100 00000000 00 00000000 00000000 0 00000000
4 01000100 00000000 00 00000000 00000000 0 00000000
4 00000010 00000000 00 00000000 00000000 1 00000102
4 00000100 00000008 00 00000000 00000000 1 CAFE1234
4 00000010 00000000 00 00000000 00000000 1 CAFE1234
5 06028000 00000008 00 00000000 00000000 0 00000000
5 00000220 00000000 00 00000000 00000000 5 00000001
5 06008000 00000008 00 00080000 00000000 0 00000000
5 00000220 00000000 00 00000000 00000000 5 00000000
5 06008000 00000004 00 00100000 00000000 0 00000000
5 00000220 00000000 00 00000000 00000000 5 00000001
5 04000000 00000008 00 00000000 00000000 0 00000000
5 00000000 00000000 00 00000000 00000000 5 00000000
5 00000000 00000000 00 00000000 00000000 4 CAFE1234

//--- src.f
common/datapath_pkg.sv
source/register_file.sv
source/ir_select_encode.sv
source/special_regs.sv
source/bus_mux.sv
alu/alu.sv
source/con_ff_logic.sv
source/datapath.sv
tb/clock_gen.sv
tb/datapath_asserts.sv
tb/datapath_tb.sv

//--- Bender.yml
package:
  name: datapath

sources:
  - common/datapath_pkg.sv
  - source/register_file.sv
  - source/ir_select_encode.sv
  - source/special_regs.sv
  - source/bus_mux.sv
  - alu/alu.sv
  - source/con_ff_logic.sv
  - source/datapath.sv
  - target: simulation
    files:
      - tb/clock_gen.sv
      - tb/datapath_asserts.sv
      - tb/datapath_tb.sv

//--- tb/datapath_tb.sv
`default_nettype none

module datapath_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import datapath_pkg::*;

    localparam int max_steps = 128;
    localparam int step_words = 8;

    logic        clock;
    logic        rst_n;
    logic        hi_drive, lo_drive, zhigh_drive, zlow_drive;
    logic        pc_drive, mdr_drive, in_port_drive, c_drive;
    logic        pc_load, ir_load, y_load, z_load, hi_load, lo_load;
    logic        mar_load, mdr_load, in_port_load, out_port_load;
    logic        gra, grb, grc, reg_in, reg_out, ba_out, inc_pc, mem_read, con_in;
    logic [15:0] reg_load_ext;
    logic [15:0] reg_drive_ext;
    alu_op_t     operation;
    logic [31:0] mem_data;
    logic [31:0] in_port_data;
    logic [31:0] bus_data;
    logic [31:0] mar_address;
    logic [31:0] mdr_write_data;
    logic [31:0] out_port_data;
    logic        con_flag;

    logic [31:0] stim [0:max_steps*step_words-1];
    string       test_names [6] = '{"reset_values", "memory_path", "alu_ops",
                                    "ir_decode", "pc_update", "branch_condition"};
    int          step_count = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    int          mismatch_count = 0;
    int          failure_count = 0;
    logic        mdr_valid = 1'b1;  // MDR clears in reset
    logic [31:0] mdr_expected = '0;

    clock_gen u_clock_gen (.clock(clock), .rst_n(rst_n));

    datapath #(.reset_pc(32'h0000_0100)) dut (.*);

    task automatic apply_step(input int s);
        logic [31:0] strobes;
        strobes = stim[s*step_words+1];
        {con_in, mem_read, inc_pc, ba_out, reg_out, reg_in, grc, grb, gra,
         out_port_load, in_port_load, mdr_load, mar_load, lo_load, hi_load,
         z_load, y_load, ir_load, pc_load, c_drive, in_port_drive, mdr_drive,
         pc_drive, zlow_drive, zhigh_drive, lo_drive, hi_drive} = strobes[26:0];
        reg_load_ext  = stim[s*step_words+2][31:16];
        reg_drive_ext = stim[s*step_words+2][15:0];
        operation     = alu_op_t'(stim[s*step_words+3][4:0]);
        mem_data      = stim[s*step_words+4];
        in_port_data  = stim[s*step_words+5];
    endtask

    task automatic check_step(input int s);
        int          name_index;
        logic [31:0] expected;
        logic [31:0] actual;
        name_index = stim[s*step_words];
        expected   = stim[s*step_words+7];
        actual     = '0;
        case (stim[s*step_words+6])
            0: return;
            1: actual = bus_data;
            2: actual = mar_address;
            3: actual = mdr_write_data;
            4: actual = out_port_data;
            5: actual = {31'b0, con_flag};
            default: begin
                $display("step %0d has an unknown check selector", s);
                failure_count++;
                return;
            end
        endcase
        if (actual !== expected) begin
            $display("MISMATCH %s step %0d: expected %h, actual %h",
                     test_names[name_index], s, expected, actual);
            mismatch_count++;
        end
    endtask

    // MDR holds the memory word of its last load with mem_read
    task automatic check_mdr_contents(input int s);
        int name_index;
        name_index = stim[s*step_words];
        if (mdr_valid && mdr_write_data !== mdr_expected) begin
            $display("MISMATCH %s step %0d: expected mdr %h, actual %h",
                     test_names[name_index], s, mdr_expected, mdr_write_data);
            mismatch_count++;
        end
        if (mdr_load) begin
            mdr_valid    = mem_read;
            mdr_expected = mem_data;
        end
    endtask

    // Run limit covers every step plus the reset cycles
    always @(posedge clock) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles, the steps did not complete", cycle_count);
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        {hi_drive, lo_drive, zhigh_drive, zlow_drive, pc_drive, mdr_drive} = '0;
        {in_port_drive, c_drive, pc_load, ir_load, y_load, z_load} = '0;
        {hi_load, lo_load, mar_load, mdr_load, in_port_load, out_port_load} = '0;
        {gra, grb, grc, reg_in, reg_out, ba_out, inc_pc, mem_read, con_in} = '0;
        reg_load_ext  = '0;
        reg_drive_ext = '0;
        operation     = alu_add;
        mem_data      = '0;
        in_port_data  = '0;
        $readmemh("tb/datapath_stimulus.txt", stim);
        while (step_count < max_steps && !$isunknown(stim[step_count*step_words])) begin
            step_count++;
        end
        if (step_count == 0) begin
            $display("the stimulus file holds no steps");
            failure_count++;
        end
        cycle_limit = step_count + 8 + 20;
        @(posedge rst_n);
        for (int s = 0; s < step_count; s++) begin
            @(posedge clock);
            #1 apply_step(s);
            @(negedge clock);
            #1 check_step(s);  // Just before the next rising edge
            check_mdr_contents(s);
        end
        $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatch_count, failure_count, dut.u_datapath_asserts.error_count);
        if (mismatch_count == 0 && failure_count == 0
            && dut.u_datapath_asserts.error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/datapath_asserts.sv
`default_nettype none

module datapath_asserts (
    input wire logic        clock,
    input wire logic        rst_n,
    input wire logic        con_in,
    input wire logic        con_flag,
    input wire logic [31:0] bus_data,
    input wire logic [15:0] reg_load,
    input wire logic        pc_load,
    input wire logic        ir_load,
    input wire logic        y_load,
    input wire logic        z_load,
    input wire logic        hi_load,
    input wire logic        lo_load,
    input wire logic        mar_load,
    input wire logic        mdr_load,
    input wire logic        out_port_load,
    input wire logic        hi_drive,
    input wire logic        lo_drive,
    input wire logic        zhigh_drive,
    input wire logic        zlow_drive,
    input wire logic        pc_drive,
    input wire logic        mdr_drive,
    input wire logic        in_port_drive,
    input wire logic        c_drive
);

    timeunit 1ns;
    timeprecision 100ps;

    logic any_load;
    int   error_count = 0;

    assign any_load = (|reg_load) | pc_load | ir_load | y_load | z_load | hi_load | lo_load
                      | mar_load | mdr_load | out_port_load;

    // The flag leaves reset clear and only con_in can set it
    flag_stays_clear: assert property (
        @(posedge clock) disable iff (!rst_n) (!con_in && !con_flag) |=> !con_flag)
        else begin
            $error("con_flag set without con_in");
            error_count++;
        end

    bus_known_on_load: assert property (
        @(posedge clock) disable iff (!rst_n) any_load |-> !$isunknown(bus_data))
        else begin
            $error("bus_data unknown while a register loads");
            error_count++;
        end

    single_drive: assert property (
        @(posedge clock) disable iff (!rst_n)
        $onehot0({hi_drive, lo_drive, zhigh_drive, zlow_drive,
                  pc_drive, mdr_drive, in_port_drive, c_drive}))
        else begin
            $error("more than one special drive strobe active");
            error_count++;
        end

endmodule

bind datapath datapath_asserts u_datapath_asserts (.*);

`default_nettype wire

//--- tb/clock_gen.sv
`default_nettype none

module clock_gen (
    output logic clock,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;  // 4 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clock);
        #1 rst_n = 1'b1;  // Release away from the edge
    end

endmodule

`default_nettype wire

//--- source/datapath.sv
`default_nettype none

module datapath #(
    parameter logic [datapath_pkg::word_width-1:0] reset_pc = 32'h0000_0010
) (
    input  logic                                 clock,
    input  logic                                 rst_n,
    input  logic                                 hi_drive,
    input  logic                                 lo_drive,
    input  logic                                 zhigh_drive,
    input  logic                                 zlow_drive,
    input  logic                                 pc_drive,
    input  logic                                 mdr_drive,
    input  logic                                 in_port_drive,
    input  logic                                 c_drive,
    input  logic                                 pc_load,
    input  logic                                 ir_load,
    input  logic                                 y_load,
    input  logic                                 z_load,
    input  logic                                 hi_load,
    input  logic                                 lo_load,
    input  logic                                 mar_load,
    input  logic                                 mdr_load,
    input  logic                                 in_port_load,
    input  logic                                 out_port_load,
    input  logic                                 gra,
    input  logic                                 grb,
    input  logic                                 grc,
    input  logic                                 reg_in,
    input  logic                                 reg_out,
    input  logic                                 ba_out,
    input  logic                                 inc_pc,
    input  logic                                 mem_read,
    input  logic                                 con_in,
    input  logic [datapath_pkg::reg_count-1:0]   reg_load_ext,
    input  logic [datapath_pkg::reg_count-1:0]   reg_drive_ext,
    input  datapath_pkg::alu_op_t                operation,
    input  logic [datapath_pkg::word_width-1:0]  mem_data,
    input  logic [datapath_pkg::word_width-1:0]  in_port_data,
    output logic [datapath_pkg::word_width-1:0]  bus_data,
    output logic [datapath_pkg::word_width-1:0]  mar_address,
    output logic [datapath_pkg::word_width-1:0]  mdr_write_data,
    output logic [datapath_pkg::word_width-1:0]  out_port_data,
    output logic                                 con_flag
);

    import datapath_pkg::*;

    logic [reg_count-1:0][word_width-1:0] reg_q;
    logic [reg_count-1:0]                 reg_load;
    logic [reg_count-1:0]                 reg_drive;
    logic [word_width-1:0]                c_sign_extended;
    ir_word_t                             ir;
    logic [word_width-1:0]                y_q;
    logic [word_width-1:0]                zhigh_q;
    logic [word_width-1:0]                zlow_q;
    logic [word_width-1:0]                hi_q;
    logic [word_width-1:0]                lo_q;
    logic [word_width-1:0]                pc_q;
    logic [word_width-1:0]                in_port_q;
    logic [2*word_width-1:0]              alu_result;

    register_file u_register_file (.*);

    ir_select_encode u_ir_select_encode (.*);

    special_regs #(
        .reset_pc(reset_pc)
    ) u_special_regs (
        .mdr_q(mdr_write_data),  // MDR contents go straight out to memory
        .*
    );

    bus_mux u_bus_mux (
        .mdr_q(mdr_write_data),
        .*
    );

    alu u_alu (
        .a        (y_q),
        .b        (bus_data),
        .operation(operation),
        .result   (alu_result)
    );

    con_ff_logic u_con_ff_logic (.*);

endmodule

`default_nettype wire

//--- source/con_ff_logic.sv
`default_nettype none

module con_ff_logic (
    input  logic                                clock,
    input  logic                                rst_n,
    input  datapath_pkg::ir_word_t              ir,
    input  logic [datapath_pkg::word_width-1:0] bus_data,
    input  logic                                con_in,
    output logic                                con_flag
);

    import datapath_pkg::*;

    branch_cond_t condition;
    logic         is_zero;
    logic         condition_met;

    assign condition = branch_cond_t'(ir.imm_form.rb[1:0]);  // IR[20:19]
    assign is_zero = (bus_data == '0);

    always_comb begin
        case (condition)
            cond_zero:     condition_met = is_zero;
            cond_nonzero:  condition_met = !is_zero;
            cond_positive: condition_met = !bus_data[word_width-1] && !is_zero;
            default:       condition_met = bus_data[word_width-1];
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            con_flag <= 1'b0;
        end else if (con_in) begin
            con_flag <= condition_met;
        end
    end

endmodule

`default_nettype wire

//--- alu/alu.sv
`default_nettype none

module alu (
    input  logic [datapath_pkg::word_width-1:0]   a,
    input  logic [datapath_pkg::word_width-1:0]   b,
    input  datapath_pkg::alu_op_t                 operation,
    output logic [2*datapath_pkg::word_width-1:0] result
);

    import datapath_pkg::*;

    logic [$clog2(word_width)-1:0]  amount;
    logic signed [2*word_width-1:0] product;
    logic [2*word_width-1:0]        rotate_right;
    logic [2*word_width-1:0]        rotate_left;
    logic [word_width-1:0]          low;

    assign amount = b[$clog2(word_width)-1:0];
    assign product = $signed(a) * $signed(b);
    assign rotate_right = {a, a} >> amount;  // Low half holds the rotated word
    assign rotate_left = {a, a} << amount;  // High half holds the rotated word

    always_comb begin
        case (operation)
            alu_add: begin
                low = a + b;
            end
            alu_sub: begin
                low = a - b;
            end
            alu_and: begin
                low = a & b;
            end
            alu_or: begin
                low = a | b;
            end
            alu_shr: begin
                low = a >> amount;
            end
            alu_shra: begin
                low = $signed(a) >>> amount;
            end
            alu_shl: begin
                low = a << amount;
            end
            alu_ror: begin
                low = rotate_right[word_width-1:0];
            end
            alu_rol: begin
                low = rotate_left[2*word_width-1:word_width];
            end
            alu_mul: begin
                low = product[word_width-1:0];
            end
            alu_neg: begin
                low = -b;
            end
            alu_not: begin
                low = ~b;
            end
            default: begin
                low = '0;
            end
        endcase
    end

    // Only the multiply produces a true upper half
    assign result = (operation == alu_mul) ? product : {{word_width{low[word_width-1]}}, low};

endmodule

`default_nettype wire

//--- source/bus_mux.sv
`default_nettype none

module bus_mux (
    input  logic [datapath_pkg::reg_count-1:0][datapath_pkg::word_width-1:0] reg_q,
    input  logic [datapath_pkg::reg_count-1:0]    reg_drive,
    input  logic [datapath_pkg::reg_count-1:0]    reg_drive_ext,
    input  logic [datapath_pkg::word_width-1:0]   hi_q,
    input  logic [datapath_pkg::word_width-1:0]   lo_q,
    input  logic [datapath_pkg::word_width-1:0]   zhigh_q,
    input  logic [datapath_pkg::word_width-1:0]   zlow_q,
    input  logic [datapath_pkg::word_width-1:0]   pc_q,
    input  logic [datapath_pkg::word_width-1:0]   mdr_q,
    input  logic [datapath_pkg::word_width-1:0]   in_port_q,
    input  logic [datapath_pkg::word_width-1:0]   c_sign_extended,
    input  logic                                  hi_drive,
    input  logic                                  lo_drive,
    input  logic                                  zhigh_drive,
    input  logic                                  zlow_drive,
    input  logic                                  pc_drive,
    input  logic                                  mdr_drive,
    input  logic                                  in_port_drive,
    input  logic                                  c_drive,
    output logic [datapath_pkg::word_width-1:0]   bus_data
);

    import datapath_pkg::*;

    localparam int source_count = reg_count + 8;

    logic [source_count-1:0]                 request;
    logic [source_count-1:0][word_width-1:0] sources;
    logic [4:0]                              select;
    logic                                    found;

    assign request = {c_drive, in_port_drive, mdr_drive, pc_drive,
                      zlow_drive, zhigh_drive, lo_drive, hi_drive,
                      reg_drive | reg_drive_ext};
    assign sources = {c_sign_extended, in_port_q, mdr_q, pc_q, zlow_q, zhigh_q, lo_q, hi_q, reg_q};

    // Lowest index wins
    always_comb begin
        select = '0;
        found  = 1'b0;
        for (int i = source_count - 1; i >= 0; i--) begin
            if (request[i]) begin
                select = 5'(i);
                found  = 1'b1;
            end
        end
    end

    assign bus_data = found ? sources[select] : '0;  // Idle bus reads as zero

endmodule

`default_nettype wire

//--- source/special_regs.sv
`default_nettype none

module special_regs #(
    parameter logic [datapath_pkg::word_width-1:0] reset_pc = '0
) (
    input  logic                                   clock,
    input  logic                                   rst_n,
    input  logic [datapath_pkg::word_width-1:0]    bus_data,
    input  logic [2*datapath_pkg::word_width-1:0]  alu_result,
    input  logic [datapath_pkg::word_width-1:0]    mem_data,
    input  logic [datapath_pkg::word_width-1:0]    in_port_data,
    input  logic                                   pc_load,
    input  logic                                   ir_load,
    input  logic                                   y_load,
    input  logic                                   z_load,
    input  logic                                   hi_load,
    input  logic                                   lo_load,
    input  logic                                   mar_load,
    input  logic                                   mdr_load,
    input  logic                                   in_port_load,
    input  logic                                   out_port_load,
    input  logic                                   inc_pc,
    input  logic                                   mem_read,
    output datapath_pkg::ir_word_t                 ir,
    output logic [datapath_pkg::word_width-1:0]    y_q,
    output logic [datapath_pkg::word_width-1:0]    zhigh_q,
    output logic [datapath_pkg::word_width-1:0]    zlow_q,
    output logic [datapath_pkg::word_width-1:0]    hi_q,
    output logic [datapath_pkg::word_width-1:0]    lo_q,
    output logic [datapath_pkg::word_width-1:0]    pc_q,
    output logic [datapath_pkg::word_width-1:0]    mdr_q,
    output logic [datapath_pkg::word_width-1:0]    in_port_q,
    output logic [datapath_pkg::word_width-1:0]    mar_address,
    output logic [datapath_pkg::word_width-1:0]    out_port_data
);

    import datapath_pkg::*;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= reset_pc;
        end else if (pc_load) begin
            pc_q <= inc_pc ? pc_q + 1'b1 : bus_data;  // Increment takes priority over the bus
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            ir            <= '0;
            y_q           <= '0;
            zhigh_q       <= '0;
            zlow_q        <= '0;
            hi_q          <= '0;
            lo_q          <= '0;
            mdr_q         <= '0;
            in_port_q     <= '0;
            mar_address   <= '0;
            out_port_data <= '0;
        end else begin
            if (ir_load) ir <= bus_data;
            if (y_load) y_q <= bus_data;
            if (z_load) begin
                zhigh_q <= alu_result[2*word_width-1:word_width];
                zlow_q  <= alu_result[word_width-1:0];
            end
            if (hi_load) hi_q <= bus_data;
            if (lo_load) lo_q <= bus_data;
            if (mdr_load) mdr_q <= mem_read ? mem_data : bus_data;
            if (in_port_load) in_port_q <= in_port_data;
            if (mar_load) mar_address <= bus_data;
            if (out_port_load) out_port_data <= bus_data;
        end
    end

endmodule

`default_nettype wire

//--- source/ir_select_encode.sv
`default_nettype none

module ir_select_encode (
    input  datapath_pkg::ir_word_t                ir,
    input  logic                                  gra,
    input  logic                                  grb,
    input  logic                                  grc,
    input  logic                                  reg_in,
    input  logic                                  reg_out,
    input  logic [datapath_pkg::reg_count-1:0]    reg_load_ext,
    output logic [datapath_pkg::reg_count-1:0]    reg_load,
    output logic [datapath_pkg::reg_count-1:0]    reg_drive,
    output logic [datapath_pkg::word_width-1:0]   c_sign_extended
);

    import datapath_pkg::*;

    logic [reg_index_width-1:0] index;
    logic [reg_count-1:0]       decoded;
    logic [reg_count-1:0]       load_decoded;

    always_comb begin
        index = '0;
        if (gra) begin
            index = ir.reg_form.ra;
        end else if (grb) begin
            index = ir.reg_form.rb;
        end else if (grc) begin
            index = ir.reg_form.rc;
        end
        decoded = '0;
        decoded[index] = gra | grb | grc;
    end

    assign load_decoded = reg_in ? decoded : '0;
    assign reg_load = (load_decoded != '0) ? load_decoded : reg_load_ext;  // External loads when no field is selected
    assign reg_drive = reg_out ? decoded : '0;

    assign c_sign_extended = {{(word_width - c_width){ir.imm_form.c[c_width-1]}}, ir.imm_form.c};

endmodule

`default_nettype wire

//--- source/register_file.sv
`default_nettype none

module register_file (
    input  logic                                 clock,
    input  logic                                 rst_n,
    input  logic [datapath_pkg::reg_count-1:0]   reg_load,
    input  logic                                 ba_out,
    input  logic [datapath_pkg::word_width-1:0]  bus_data,
    output logic [datapath_pkg::reg_count-1:0][datapath_pkg::word_width-1:0] reg_q
);

    import datapath_pkg::*;

    logic [reg_count-1:0][word_width-1:0] regs;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            regs <= '0;
        end else begin
            for (int i = 0; i < reg_count; i++) begin
                if (reg_load[i]) begin
                    regs[i] <= bus_data;
                end
            end
        end
    end

    // R0 reads as zero for base-address arithmetic
    always_comb begin
        reg_q = regs;
        if (ba_out) begin
            reg_q[0] = '0;
        end
    end

endmodule

`default_nettype wire

//--- common/datapath_pkg.sv
`default_nettype none

package datapath_pkg;

    localparam int word_width = 32;
    localparam int reg_count = 16;
    localparam int reg_index_width = $clog2(reg_count);
    localparam int opcode_width = 5;
    localparam int c_width = 19;

    // One instruction word, read as a register form or as an immediate form
    typedef union packed {
        struct packed {
            logic [opcode_width-1:0]    opcode;
            logic [reg_index_width-1:0] ra;
            logic [reg_index_width-1:0] rb;
            logic [reg_index_width-1:0] rc;
            logic [14:0]                unused;
        } reg_form;
        struct packed {
            logic [opcode_width-1:0]    opcode;
            logic [reg_index_width-1:0] ra;
            logic [reg_index_width-1:0] rb;  // Low two bits are the branch condition
            logic [c_width-1:0]         c;
        } imm_form;
    } ir_word_t;

    typedef enum logic [opcode_width-1:0] {
        alu_add  = 5'b00011,
        alu_sub  = 5'b00100,
        alu_and  = 5'b00101,
        alu_or   = 5'b00110,
        alu_ror  = 5'b00111,
        alu_rol  = 5'b01000,
        alu_shr  = 5'b01001,
        alu_shra = 5'b01010,
        alu_shl  = 5'b01011,
        alu_mul  = 5'b10000,
        alu_neg  = 5'b10001,
        alu_not  = 5'b10010
    } alu_op_t;

    typedef enum logic [1:0] {
        cond_zero     = 2'b00,
        cond_nonzero  = 2'b01,
        cond_positive = 2'b10,
        cond_negative = 2'b11
    } branch_cond_t;

endpackage

`default_nettype wire
